/* busSystem.f */
common/busPkg.sv
hw/ahbBus/ahbBusUnit.sv
hw/ahbRam/ahbRam.sv
hw/loadAlign.sv
hw/busSystem.sv
verification/busSystemTb.sv

/* common/busPkg.sv */
// Shared widths, bus-unit states and AHB-Lite codes
// Only a 32-bit data bus and 32-bit physical addresses are supported
`default_nettype none

package busPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Register and bus data width
  localparam int xlen = 32;
  // Physical address width
  localparam int paBits = 32;
  // Byte offset bits within one bus word
  localparam int offBits = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Bus unit states
  ////////////////////////////////////////////////////////////////////////////

  // Shared so that assertions and wave dumps decode the same way
  typedef enum logic [1:0] {
    IDLE,
    MEMREAD,
    MEMWRITE,
    INSTRREAD
  } busStateT;

  ////////////////////////////////////////////////////////////////////////////
  // AHB-Lite codes
  ////////////////////////////////////////////////////////////////////////////

  // HTRANS, only single transfers are issued
  localparam logic [1:0] htransIdle = 2'b00;
  localparam logic [1:0] htransNonseq = 2'b10;

  // Access size, same encoding as the low bits of HSIZE
  localparam logic [1:0] sizeByte = 2'd0;
  localparam logic [1:0] sizeHalf = 2'd1;
  localparam logic [1:0] sizeWord = 2'd2;

endpackage

`default_nettype wire

/* hw/ahbBus/ahbBusUnit.sv */
// AHB-Lite master arbitrating a fetch stream and a load/store stream
// Single NONSEQ transfers only, HRESP is not acted on
// Requesters hold address and data stable until their ack
`timescale 1ns/1ps
`default_nettype none

module ahbBusUnit (
  input  wire logic                         clk,
  input  wire logic                         rstN,
  // Load control
  input  wire logic                         unsignedLoad,
  // Fetch side
  input  wire logic [busPkg::paBits-1:0]    ifuBusAdr,
  input  wire logic                         ifuBusRead,
  output logic      [busPkg::xlen-1:0]      ifuBusHRDATA,
  output logic                              ifuBusAck,
  // Load/store side
  input  wire logic [busPkg::paBits-1:0]    lsuBusAdr,
  input  wire logic                         lsuBusRead,
  input  wire logic                         lsuBusWrite,
  input  wire logic [busPkg::xlen-1:0]      lsuBusHWDATA,
  input  wire logic [1:0]                   lsuBusSize,
  output logic      [busPkg::xlen-1:0]      lsuBusHRDATA,
  output logic                              lsuBusAck,
  // AHB-Lite bus
  input  wire logic [busPkg::xlen-1:0]      HRDATA,
  input  wire logic                         HREADY,
  input  wire logic                         HRESP,
  output logic      [busPkg::paBits-1:0]    HADDR,
  output logic      [busPkg::xlen-1:0]      HWDATA,
  output logic                              HWRITE,
  output logic      [2:0]                   HSIZE,
  output logic      [1:0]                   HTRANS,
  // Delayed offset and {unsigned, size} for the load aligner
  output logic      [busPkg::offBits-1:0]   haddrD,
  output logic      [2:0]                   hsizeD
);

  busPkg::busStateT state;
  busPkg::busStateT nextState;
  logic             grantData;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= busPkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  // Data wins at idle, but a fetch already on the bus always completes
  // HREADY low holds the current state
  always_comb begin
    case (state)
      busPkg::IDLE: begin
        if (lsuBusRead) nextState = busPkg::MEMREAD;
        else if (lsuBusWrite) nextState = busPkg::MEMWRITE;
        else if (ifuBusRead) nextState = busPkg::INSTRREAD;
        else nextState = busPkg::IDLE;
      end
      busPkg::MEMREAD,
      busPkg::MEMWRITE: begin
        // Pending fetch starts its address phase in the data ack cycle
        if (!HREADY) nextState = state;
        else if (ifuBusRead) nextState = busPkg::INSTRREAD;
        else nextState = busPkg::IDLE;
      end
      busPkg::INSTRREAD: begin
        if (!HREADY) nextState = busPkg::INSTRREAD;
        else nextState = busPkg::IDLE;
      end
      default: nextState = busPkg::IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address phase, straight from the next state
  ////////////////////////////////////////////////////////////////////////////

  assign grantData = (nextState == busPkg::MEMREAD) || (nextState == busPkg::MEMWRITE);

  assign HADDR  = grantData ? lsuBusAdr : ifuBusAdr;
  // Fetches are always full words
  assign HSIZE  = grantData ? {1'b0, lsuBusSize} : {1'b0, busPkg::sizeWord};
  assign HTRANS = (nextState != busPkg::IDLE) ? busPkg::htransNonseq : busPkg::htransIdle;
  assign HWRITE = (nextState == busPkg::MEMWRITE);

  // Data phase values lag the address phase by one cycle
  // Write data is already lane placed by the requester
  always_ff @(posedge clk) begin
    HWDATA <= lsuBusHWDATA;
    haddrD <= HADDR[busPkg::offBits-1:0];
    hsizeD <= {unsignedLoad, HSIZE[1:0]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Return path
  ////////////////////////////////////////////////////////////////////////////

  // Both streams see the raw bus word
  assign ifuBusHRDATA = HRDATA;
  assign lsuBusHRDATA = HRDATA;

  // Ack pulses when the owning state is left with HREADY high
  assign ifuBusAck = (state == busPkg::INSTRREAD) && HREADY;
  assign lsuBusAck = ((state == busPkg::MEMREAD) || (state == busPkg::MEMWRITE)) && HREADY;

  // Only one stream completes per cycle
  assert property (@(posedge clk) disable iff (!rstN)
    !(ifuBusAck && lsuBusAck));

  // A write transfer is only driven for a live store request
  assert property (@(posedge clk) disable iff (!rstN)
    HWRITE |-> lsuBusWrite);

endmodule

`default_nettype wire

/* hw/ahbRam/ahbRam.sv */
// AHB-Lite RAM slave, word array of memWords entries, no error response
// Upper address bits beyond the array wrap, contents start at zero
// waitStates wait cycles are inserted in every data phase
`timescale 1ns/1ps
`default_nettype none

module ahbRam #(
  parameter int memWords   = 256,
  parameter int waitStates = 1
) (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  // Address phase
  input  wire logic [busPkg::xlen-1:0]    HADDR,
  input  wire logic                       HWRITE,
  input  wire logic [2:0]                 HSIZE,
  input  wire logic [1:0]                 HTRANS,
  // Data phase
  input  wire logic [busPkg::xlen-1:0]    HWDATA,
  output logic      [busPkg::xlen-1:0]    HRDATA,
  output logic                            HREADY,
  output logic                            HRESP
);

  localparam int wordBits = (memWords > 1) ? $clog2(memWords) : 1;
  localparam int cntBits  = (waitStates > 0) ? $clog2(waitStates + 1) : 1;
  localparam int lanes    = busPkg::xlen / 8;

  logic [busPkg::xlen-1:0]    mem [memWords];

  logic                       addrAccept;
  logic                       dataPhase;
  logic [cntBits-1:0]         waitCnt;
  logic                       dWrite;
  logic [wordBits-1:0]        dIndex;
  logic [busPkg::offBits-1:0] dOffset;
  logic [1:0]                 dSize;
  logic [lanes-1:0]           laneMask;

  initial begin
    for (int i = 0; i < memWords; i++) begin
      mem[i] = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address phase capture
  ////////////////////////////////////////////////////////////////////////////

  assign addrAccept = (HTRANS == busPkg::htransNonseq) && HREADY;

  // Transfer details for the data phase
  always_ff @(posedge clk) begin
    if (addrAccept) begin
      dIndex  <= HADDR[busPkg::offBits +: wordBits];
      dOffset <= HADDR[busPkg::offBits-1:0];
      dSize   <= HSIZE[1:0];
    end
  end

  // Data phase tracking and wait counter
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataPhase <= 1'b0;
      dWrite    <= 1'b0;
      waitCnt   <= '0;
    end else if (HREADY) begin
      // Next transfer can start in the last cycle of the current one
      dataPhase <= addrAccept;
      dWrite    <= addrAccept && HWRITE;
      waitCnt   <= addrAccept ? cntBits'(waitStates) : '0;
    end else begin
      waitCnt   <= waitCnt - 1'b1;
    end
  end

  // Stall while wait cycles remain
  assign HREADY = !(dataPhase && (waitCnt != '0));
  // Always OKAY
  assign HRESP  = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Byte lanes touched by the registered offset and size
  always_comb begin
    case (dSize)
      busPkg::sizeByte: laneMask = lanes'(1) << dOffset;
      busPkg::sizeHalf: laneMask = lanes'(3) << {dOffset[busPkg::offBits-1:1], 1'b0};
      default:          laneMask = '1;
    endcase
  end

  // Write lands on the completing cycle, HWDATA is valid by then
  always_ff @(posedge clk) begin
    if (dataPhase && dWrite && HREADY) begin
      for (int b = 0; b < lanes; b++) begin
        if (laneMask[b]) begin
          mem[dIndex][8*b +: 8] <= HWDATA[8*b +: 8];
        end
      end
    end
  end

  // Whole addressed word, the master picks out subwords
  assign HRDATA = mem[dIndex];

  // Accepted transfers are naturally aligned and at most one word wide
  assert property (@(posedge clk) disable iff (!rstN)
    addrAccept |-> (!HSIZE[2] &&
      ((HSIZE[1:0] == busPkg::sizeWord) ? (HADDR[1:0] == 2'b00) :
       (HSIZE[1:0] == busPkg::sizeHalf) ? !HADDR[0] : 1'b1)));

endmodule

`default_nettype wire

/* hw/busSystem.sv */
// Bus subsystem top, bus unit driving an on-chip RAM slave
// AHB signals are brought out for observation only
`timescale 1ns/1ps
`default_nettype none

module busSystem #(
  parameter int memWords   = 256,
  parameter int waitStates = 1
) (
  input  wire logic                         clk,
  input  wire logic                         rstN,
  // Fetch side
  input  wire logic [busPkg::paBits-1:0]    ifuBusAdr,
  input  wire logic                         ifuBusRead,
  output logic      [busPkg::xlen-1:0]      ifuBusHRDATA,
  output logic                              ifuBusAck,
  // Load/store side
  input  wire logic [busPkg::paBits-1:0]    lsuBusAdr,
  input  wire logic                         lsuBusRead,
  input  wire logic                         lsuBusWrite,
  input  wire logic [busPkg::xlen-1:0]      lsuBusHWDATA,
  input  wire logic [1:0]                   lsuBusSize,
  input  wire logic                         unsignedLoad,
  output logic                              lsuBusAck,
  output logic      [busPkg::xlen-1:0]      lsuLoadData,
  // AHB-Lite observation
  output logic      [busPkg::paBits-1:0]    HADDR,
  output logic      [busPkg::xlen-1:0]      HWDATA,
  output logic                              HWRITE,
  output logic      [2:0]                   HSIZE,
  output logic      [1:0]                   HTRANS,
  output logic      [busPkg::xlen-1:0]      HRDATA,
  output logic                              HREADY,
  output logic                              HRESP
);

  // Raw load word and its delayed lane info
  logic [busPkg::xlen-1:0]    lsuBusHRDATA;
  logic [busPkg::offBits-1:0] haddrD;
  logic [2:0]                 hsizeD;

  ////////////////////////////////////////////////////////////////////////////
  // Master, slave and load path
  ////////////////////////////////////////////////////////////////////////////

  ahbBusUnit i_ahbBusUnit (
    .clk          (clk),
    .rstN         (rstN),
    .unsignedLoad (unsignedLoad),
    .ifuBusAdr    (ifuBusAdr),
    .ifuBusRead   (ifuBusRead),
    .ifuBusHRDATA (ifuBusHRDATA),
    .ifuBusAck    (ifuBusAck),
    .lsuBusAdr    (lsuBusAdr),
    .lsuBusRead   (lsuBusRead),
    .lsuBusWrite  (lsuBusWrite),
    .lsuBusHWDATA (lsuBusHWDATA),
    .lsuBusSize   (lsuBusSize),
    .lsuBusHRDATA (lsuBusHRDATA),
    .lsuBusAck    (lsuBusAck),
    .HRDATA       (HRDATA),
    .HREADY       (HREADY),
    .HRESP        (HRESP),
    .HADDR        (HADDR),
    .HWDATA       (HWDATA),
    .HWRITE       (HWRITE),
    .HSIZE        (HSIZE),
    .HTRANS       (HTRANS),
    .haddrD       (haddrD),
    .hsizeD       (hsizeD)
  );

  ahbRam #(
    .memWords   (memWords),
    .waitStates (waitStates)
  ) i_ahbRam (
    .clk    (clk),
    .rstN   (rstN),
    .HADDR  (HADDR),
    .HWRITE (HWRITE),
    .HSIZE  (HSIZE),
    .HTRANS (HTRANS),
    .HWDATA (HWDATA),
    .HRDATA (HRDATA),
    .HREADY (HREADY),
    .HRESP  (HRESP)
  );

  // Valid in the load ack cycle
  loadAlign i_loadAlign (
    .busWord  (lsuBusHRDATA),
    .haddrD   (haddrD),
    .hsizeD   (hsizeD),
    .loadData (lsuLoadData)
  );

endmodule

`default_nettype wire

/* hw/loadAlign.sv */
// Load data extraction from the returned bus word
// Purely combinational, driven by the one-cycle delayed offset and size
`timescale 1ns/1ps
`default_nettype none

module loadAlign (
  input  wire logic [busPkg::xlen-1:0]    busWord,
  input  wire logic [busPkg::offBits-1:0] haddrD,
  // {unsigned, size}
  input  wire logic [2:0]                 hsizeD,
  output logic      [busPkg::xlen-1:0]    loadData
);

  logic [7:0]  byteVal;
  logic [15:0] halfVal;
  logic        byteSign;
  logic        halfSign;

  ////////////////////////////////////////////////////////////////////////////
  // Lane select
  ////////////////////////////////////////////////////////////////////////////

  // Byte at the delayed offset
  assign byteVal = busWord[8*haddrD +: 8];
  // Halfword, offset bit 0 ignored since accesses are aligned
  assign halfVal = busWord[16*haddrD[busPkg::offBits-1] +: 16];

  // Extension bit, forced low for unsigned loads
  assign byteSign = !hsizeD[2] && byteVal[7];
  assign halfSign = !hsizeD[2] && halfVal[15];

  ////////////////////////////////////////////////////////////////////////////
  // Extend to full width
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (hsizeD[1:0])
      busPkg::sizeByte: loadData = {{(busPkg::xlen - 8){byteSign}}, byteVal};
      busPkg::sizeHalf: loadData = {{(busPkg::xlen - 16){halfSign}}, halfVal};
      // Word loads pass through unchanged
      default:          loadData = busWord;
    endcase
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the bus subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module busSystemTb -f busSystem.f -o simBusSystem

./obj_dir/simBusSystem | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* verification/busSystemTb.sv */
// Vector-driven testbench for the bus subsystem with one RAM wait state
// Reads verification/busVectors.txt, so it must run from the project root
`timescale 1ns/1ps
`default_nettype none

module busSystemTb;

  localparam int memWords    = 256;
  localparam int waitStates  = 1;
  localparam int memBytes    = memWords * 4;
  localparam int fields      = 6;
  localparam int maxVecs     = 64;
  localparam int clkPeriod   = 100;
  localparam int driveDelay  = 5;
  localparam int resetCycles = 8;
  // Request to ack distance on an idle bus
  localparam int ackLatency  = waitStates + 1;
  localparam logic [1:0] transIdle = 2'b00;
  localparam logic [1:0] transNonseq = 2'b10;

  // Stream codes used in the vectors file
  localparam logic [31:0] streamFetch = 32'd0;
  localparam logic [31:0] streamLoad  = 32'd1;
  localparam logic [31:0] streamStore = 32'd2;
  localparam logic [31:0] streamBoth  = 32'd3;

  logic        clk;
  logic        rstN;
  logic [31:0] ifuBusAdr;
  logic        ifuBusRead;
  logic [31:0] ifuBusHRDATA;
  logic        ifuBusAck;
  logic [31:0] lsuBusAdr;
  logic        lsuBusRead;
  logic        lsuBusWrite;
  logic [31:0] lsuBusHWDATA;
  logic [1:0]  lsuBusSize;
  logic        unsignedLoad;
  logic        lsuBusAck;
  logic [31:0] lsuLoadData;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic        HWRITE;
  logic [2:0]  HSIZE;
  logic [1:0]  HTRANS;
  logic [31:0] HRDATA;
  logic        HREADY;
  logic        HRESP;

  logic [31:0] vecMem [maxVecs * fields];
  // Byte-level model of the RAM contents
  logic [7:0]  shadow [memBytes];
  int          errorCount = 0;
  int          vecCount = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;

  busSystem #(
    .memWords   (memWords),
    .waitStates (waitStates)
  ) i_busSystem (
    .clk          (clk),
    .rstN         (rstN),
    .ifuBusAdr    (ifuBusAdr),
    .ifuBusRead   (ifuBusRead),
    .ifuBusHRDATA (ifuBusHRDATA),
    .ifuBusAck    (ifuBusAck),
    .lsuBusAdr    (lsuBusAdr),
    .lsuBusRead   (lsuBusRead),
    .lsuBusWrite  (lsuBusWrite),
    .lsuBusHWDATA (lsuBusHWDATA),
    .lsuBusSize   (lsuBusSize),
    .unsignedLoad (unsignedLoad),
    .lsuBusAck    (lsuBusAck),
    .lsuLoadData  (lsuLoadData),
    .HADDR        (HADDR),
    .HWDATA       (HWDATA),
    .HWRITE       (HWRITE),
    .HSIZE        (HSIZE),
    .HTRANS       (HTRANS),
    .HRDATA       (HRDATA),
    .HREADY       (HREADY),
    .HRESP        (HRESP)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2);
      clk = ~clk;
    end
  end

  // Watchdog with its limit set once the vectors are counted
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, a request was never acknowledged", cycleCount);
      $display("Errors: %0d", errorCount);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checker and RAM model
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkVal(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
      errorCount++;
    end
  endtask

  function automatic logic [31:0] shadowWord(input logic [31:0] addr);
    int base;
    base = int'(addr % 32'(memBytes)) & ~3;
    return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
  endfunction

  // Byte at its offset, halfword at the even pair, word everywhere
  task automatic shadowStore(input logic [31:0] addr, input logic [1:0] size,
                             input logic [31:0] data);
    int base;
    int lane;
    int l;
    base = int'(addr % 32'(memBytes)) & ~3;
    lane = int'(addr[1:0]);
    for (l = 0; l < 4; l++) begin
      if (size == 2'd2 || (size == 2'd1 && (l >> 1) == (lane >> 1)) ||
          (size == 2'd0 && l == lane)) begin
        shadow[base + l] = data[8*l +: 8];
      end
    end
  endtask

  function automatic logic [31:0] shadowLoad(input logic [31:0] addr,
                                             input logic [1:0] size, input logic uns);
    int a;
    logic [7:0]  b;
    logic [15:0] h;
    a = int'(addr % 32'(memBytes));
    case (size)
      2'd0: begin
        b = shadow[a];
        return {{24{b[7] && !uns}}, b};
      end
      2'd1: begin
        h = {shadow[(a & ~1) + 1], shadow[a & ~1]};
        return {{16{h[15] && !uns}}, h};
      end
      default: return shadowWord(addr);
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Bus must look idle during and right after reset
  task automatic checkIdleBus();
    checkVal("HTRANS", 32'(HTRANS), 32'(transIdle));
    checkVal("HWRITE", 32'(HWRITE), 32'd0);
    checkVal("HREADY", 32'(HREADY), 32'd1);
    checkVal("HRESP", 32'(HRESP), 32'd0);
    checkVal("ifuBusAck", 32'(ifuBusAck), 32'd0);
    checkVal("lsuBusAck", 32'(lsuBusAck), 32'd0);
  endtask

  // Address phase that the slave should see on the bus
  task automatic checkAddrPhase(input logic [31:0] adr, input logic [2:0] sz,
                                input logic wr);
    checkVal("HTRANS", 32'(HTRANS), 32'(transNonseq));
    checkVal("HADDR", HADDR, adr);
    checkVal("HSIZE", 32'(HSIZE), 32'(sz));
    checkVal("HWRITE", 32'(HWRITE), 32'(wr));
  endtask

  // Entered and left 5 ns after a rising edge
  task automatic runVector(input int idx);
    logic [31:0] stream;
    logic [31:0] addr;
    logic [1:0]  size;
    logic        uns;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] fetchAdr;
    logic [31:0] fetchExp;
    logic [31:0] lsuWord;
    logic [31:0] lsuGot;
    logic [31:0] ifuGot;
    logic        wantLsu;
    logic        wantIfu;
    int          cyc;
    int          lsuAt;
    int          ifuAt;
    stream   = vecMem[idx * fields];
    addr     = vecMem[idx * fields + 1];
    size     = vecMem[idx * fields + 2][1:0];
    uns      = vecMem[idx * fields + 3][0];
    data     = vecMem[idx * fields + 4];
    expected = vecMem[idx * fields + 5];
    wantLsu  = (stream != streamFetch);
    wantIfu  = (stream == streamFetch) || (stream == streamBoth);
    // For a combined access the data column is the fetch address
    fetchAdr = (stream == streamBoth) ? data : addr;
    lsuGot   = '0;
    ifuGot   = '0;

    // Model and file must agree first
    if (stream == streamStore) begin
      shadowStore(addr, size, data);
      checkVal("shadow store word", shadowWord(addr), expected);
    end else if (stream == streamFetch) begin
      checkVal("shadow fetch word", shadowWord(addr), expected);
    end else begin
      checkVal("shadow load value", shadowLoad(addr, size, uns), expected);
    end
    fetchExp = shadowWord(fetchAdr);
    lsuWord  = shadowWord(addr);

    if (wantLsu) begin
      lsuBusAdr    = addr;
      lsuBusSize   = size;
      unsignedLoad = uns;
      lsuBusRead   = (stream != streamStore);
      lsuBusWrite  = (stream == streamStore);
      lsuBusHWDATA = (stream == streamStore) ? data : 32'h0;
    end
    if (wantIfu) begin
      ifuBusAdr  = fetchAdr;
      ifuBusRead = 1'b1;
    end

    // Cycle 0 is the request cycle
    cyc   = 0;
    lsuAt = -1;
    ifuAt = -1;
    while ((wantLsu && lsuAt < 0) || (wantIfu && ifuAt < 0)) begin
      @(negedge clk);
      if ((lsuBusAck && !wantLsu) || (ifuBusAck && !wantIfu)) begin
        $display("Vector %0d got an ack for a stream that made no request", idx);
        errorCount++;
      end
      // Each data phase waits, so the bus is ready only every ackLatency cycles
      checkVal("HREADY", 32'(HREADY), 32'((cyc % ackLatency) == 0));
      checkVal("HRESP", 32'(HRESP), 32'd0);
      if (cyc == 0) begin
        if (wantLsu) begin
          checkAddrPhase(addr, {1'b0, size}, stream == streamStore);
        end else begin
          checkAddrPhase(fetchAdr, 3'd2, 1'b0);
        end
      end
      if (lsuBusAck && lsuAt < 0) begin
        lsuAt  = cyc;
        lsuGot = lsuLoadData;
        if (stream == streamStore) begin
          checkVal("HWDATA", HWDATA, data);
        end else begin
          checkVal("HRDATA", HRDATA, lsuWord);
        end
        // Waiting fetch takes the bus in the data ack cycle
        if (wantIfu) begin
          checkAddrPhase(fetchAdr, 3'd2, 1'b0);
        end
      end
      if (ifuBusAck && ifuAt < 0) begin
        ifuAt  = cyc;
        ifuGot = ifuBusHRDATA;
      end
      // Request level drops in the cycle after its ack
      @(posedge clk);
      #driveDelay;
      if (lsuAt >= 0) begin
        lsuBusRead  = 1'b0;
        lsuBusWrite = 1'b0;
      end
      if (ifuAt >= 0) begin
        ifuBusRead = 1'b0;
      end
      cyc++;
    end

    if (wantLsu) begin
      checkVal("lsuBusAck latency", 32'(lsuAt), 32'(ackLatency));
    end
    if (stream == streamLoad || stream == streamBoth) begin
      checkVal("lsuLoadData", lsuGot, expected);
    end
    if (stream == streamFetch) begin
      checkVal("ifuBusAck latency", 32'(ifuAt), 32'(ackLatency));
      checkVal("ifuBusHRDATA", ifuGot, expected);
    end
    if (stream == streamBoth) begin
      // Fetch address phase sits in the data ack cycle
      checkVal("ifuBusAck after lsuBusAck", 32'(ifuAt - lsuAt), 32'(ackLatency));
      checkVal("ifuBusHRDATA", ifuGot, fetchExp);
    end

    // Idle cycle between data accesses
    @(posedge clk);
    #driveDelay;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int v;
    rstN         = 1'b0;
    ifuBusAdr    = '0;
    ifuBusRead   = 1'b0;
    lsuBusAdr    = '0;
    lsuBusRead   = 1'b0;
    lsuBusWrite  = 1'b0;
    lsuBusHWDATA = '0;
    lsuBusSize   = 2'd2;
    unsignedLoad = 1'b0;
    for (v = 0; v < memBytes; v++) begin
      shadow[v] = 8'h00;
    end
    // All ones marks the end of the vectors
    for (v = 0; v < maxVecs * fields; v++) begin
      vecMem[v] = 32'hFFFF_FFFF;
    end
    $readmemh("verification/busVectors.txt", vecMem);
    while (vecCount < maxVecs && vecMem[vecCount * fields] !== 32'hFFFF_FFFF) begin
      vecCount++;
    end
    cycleLimit = vecCount * 8 + 50;
    if (vecCount == 0) begin
      $display("No vectors could be read from the vectors file");
      errorCount++;
    end

    // Eight rising edges with reset low
    repeat (resetCycles - 1) begin
      @(negedge clk);
      checkIdleBus();
    end
    @(posedge clk);
    #driveDelay;
    rstN = 1'b1;
    @(negedge clk);
    checkIdleBus();
    @(posedge clk);
    #driveDelay;

    for (v = 0; v < vecCount; v++) begin
      runVector(v);
    end

    $display("Vectors run: %0d, errors: %0d", vecCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/busVectors.txt */
// stream (0 fetch, 1 load, 2 store, 3 both) address size (0 byte, 1 half, 2 word) unsigned data expected
// Stores hold lane-placed data and expect the whole word after the store; for both, data is the fetch address
2 00000000 2 0 11223344 11223344
1 00000000 2 0 00000000 11223344
2 00000004 2 0 8899AABB 8899AABB
1 00000004 2 0 00000000 8899AABB
2 00000001 0 0 0000F000 1122F044
1 00000001 0 0 00000000 FFFFFFF0
1 00000001 0 1 00000000 000000F0
1 00000000 0 0 00000000 00000044
2 00000006 1 0 80010000 8001AABB
1 00000006 1 0 00000000 FFFF8001
1 00000006 1 1 00000000 00008001
1 00000004 1 0 00000000 FFFFAABB
2 00000007 0 0 7F000000 7F01AABB
1 00000007 0 0 00000000 0000007F
1 00000006 1 0 00000000 00007F01
2 00000100 2 0 00000013 00000013
2 00000104 2 0 DEADBEEF DEADBEEF
0 00000100 2 0 00000000 00000013
0 00000104 2 0 00000000 DEADBEEF
0 00000008 2 0 00000000 00000000
3 00000000 2 0 00000104 1122F044
3 00000005 0 1 00000100 000000AA
2 00000002 1 0 CAFE0000 CAFEF044
1 00000002 1 1 00000000 0000CAFE
3 00000002 1 0 00000000 FFFFCAFE
2 000003FF 0 0 5A000000 5A000000
1 000003FF 0 0 00000000 0000005A
0 000003FC 2 0 00000000 5A000000
